// ==== src/rv32Core_defs.svh ====
`ifndef RV32CORE_DEFS_SVH
`define RV32CORE_DEFS_SVH

`define XLEN 32
`define REG_COUNT 32
`define REG_INDEX_BITS 5
`define MGMT_ADDR_BITS 16

// Management address fields
`define MGMT_REGION_HI 15
`define MGMT_REGION_LO 14
`define MGMT_SYS_ZERO_HI 13
`define MGMT_SYS_ZERO_LO 8
`define MGMT_SYS_SEL_HI 7
`define MGMT_SYS_SEL_LO 4
`define MGMT_REG_ZERO_HI 13
`define MGMT_REG_ZERO_LO 7
`define MGMT_REG_INDEX_HI 6
`define MGMT_REG_INDEX_LO 2

`endif

// ==== src/rv32IsaPkg.sv ====
`include "rv32Core_defs.svh"

package rv32IsaPkg;

	// Major opcodes handled by the core
	typedef enum logic [6:0] {
		opcodeOp = 7'b0110011,
		opcodeOpImm = 7'b0010011,
		opcodeLui = 7'b0110111
	} opcodeT;

	typedef enum logic [3:0] {
		aluAdd = 4'd0,
		aluSub = 4'd1,
		aluSll = 4'd2,
		aluSlt = 4'd3,
		aluSltu = 4'd4,
		aluXor = 4'd5,
		aluSrl = 4'd6,
		aluSra = 4'd7,
		aluOr = 4'd8,
		aluAnd = 4'd9,
		// LUI result is operand B as is
		aluPassB = 4'd10
	} aluOpT;

	typedef struct packed {
		logic [`XLEN-1:0] pc;
		logic [`XLEN-1:0] instruction;
	} fetchPacketT;

	typedef struct packed {
		logic [`REG_INDEX_BITS-1:0] rdIndex;
		logic writeEnable;
		logic [`XLEN-1:0] result;
	} writebackPacketT;

endpackage

// ==== src/rv32MgmtPkg.sv ====
package rv32MgmtPkg;

	// Top two address bits
	typedef enum logic [1:0] {
		regionSystem = 2'b00,
		regionRegisters = 2'b01
	} mgmtRegionT;

	// Word selector within the system region
	typedef enum logic [3:0] {
		sysProgramCounter = 4'h0,
		sysClearError = 4'h2
	} sysSelectT;

endpackage

// ==== src/pipeStage.sv ====
`timescale 1ns/1ps

module pipeStage #(
	parameter type payloadT = logic
) (
	input logic clk,
	input logic rst,
	input logic inValid,
	output logic inReady,
	input payloadT inData,
	output logic outValid,
	input logic outReady,
	output payloadT outData
);

	logic full;
	payloadT held;

	// Refill in the same cycle the held item leaves
	assign inReady = !full || outReady;
	assign outValid = full;
	assign outData = held;

	always_ff @(posedge clk) begin
		if (rst) begin
			full <= 1'b0;
		end else if (inReady) begin
			full <= inValid;
		end
	end

	always_ff @(posedge clk) begin
		if (inValid && inReady) begin
			held <= inData;
		end
	end

	assert property (@(posedge clk) disable iff (rst)
		outValid && !outReady |=> $stable(outData));

endmodule

// ==== src/instructionFetch.sv ====
`timescale 1ns/1ps
`include "rv32Core_defs.svh"

module instructionFetch (
	input logic clk,
	input logic rst,
	input logic run,
	input logic halt,
	input logic pcWriteEnable,
	input logic [`XLEN-1:0] pcWriteData,
	output logic instrReqValid,
	input logic instrReqReady,
	output logic [`XLEN-1:0] instrAddr,
	input logic instrRespValid,
	input logic [`XLEN-1:0] instrRespData,
	output logic fetchValid,
	input logic fetchReady,
	output rv32IsaPkg::fetchPacketT fetchPacket,
	input logic retire,
	input logic discard,
	output logic [`XLEN-1:0] programCounter,
	output logic [1:0] outstanding
);

	logic [`XLEN-1:0] reqAddr;
	logic [`XLEN-1:0] respAddr;
	logic [`XLEN-1:0] pcReg;
	logic [1:0] count;
	logic [1:0] countNext;
	logic accepted;
	logic dropped;
	logic quiet;

	assign accepted = instrReqValid && instrReqReady;
	assign dropped = instrRespValid && (halt || discard);
	assign quiet = !instrReqValid && count == 2'd0;

	// Discard also marks the faulting item as gone
	assign countNext = count + 2'(accepted) - 2'(retire) - 2'(discard) - 2'(dropped);

	always_ff @(posedge clk) begin
		if (rst) begin
			instrReqValid <= 1'b0;
			count <= 2'd0;
			pcReg <= '0;
			reqAddr <= '0;
			respAddr <= '0;
		end else begin
			count <= countNext;
			// A pending request is held until the memory takes it
			if (!instrReqValid || instrReqReady) begin
				instrReqValid <= run && !halt && !discard && countNext < 2'd2;
			end
			if (pcWriteEnable) begin
				pcReg <= pcWriteData;
				reqAddr <= pcWriteData;
				respAddr <= pcWriteData;
			end else if (quiet) begin
				// Resume from the last retired address
				reqAddr <= pcReg;
				respAddr <= pcReg;
			end else begin
				if (retire) pcReg <= pcReg + `XLEN'(4);
				if (accepted) reqAddr <= reqAddr + `XLEN'(4);
				if (instrRespValid) respAddr <= respAddr + `XLEN'(4);
			end
		end
	end

	assign instrAddr = reqAddr;
	assign fetchValid = instrRespValid && !halt && !discard;
	assign fetchPacket.pc = respAddr;
	assign fetchPacket.instruction = instrRespData;
	assign programCounter = pcReg;
	assign outstanding = count;

	assert property (@(posedge clk) disable iff (rst)
		instrRespValid |-> count != 2'd0);

	// Two in flight at most, so the fetch stage never pushes back
	assert property (@(posedge clk) disable iff (rst)
		fetchValid |-> fetchReady);

endmodule

// ==== src/instructionDecode.sv ====
`timescale 1ns/1ps
`include "rv32Core_defs.svh"

module instructionDecode (
	input logic [`XLEN-1:0] instruction,
	output rv32IsaPkg::aluOpT aluOp,
	output logic [`REG_INDEX_BITS-1:0] rs1Index,
	output logic [`REG_INDEX_BITS-1:0] rs2Index,
	output logic [`REG_INDEX_BITS-1:0] rdIndex,
	output logic [`XLEN-1:0] immediate,
	output logic useImmediate,
	output logic isLui,
	output logic invalid
);

	rv32IsaPkg::opcodeT opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	logic [`XLEN-1:0] iImmediate;
	logic [`XLEN-1:0] uImmediate;

	function automatic rv32IsaPkg::aluOpT aluOpFor(input logic [2:0] f3, input logic alt);
		case (f3)
			3'b000: return alt ? rv32IsaPkg::aluSub : rv32IsaPkg::aluAdd;
			3'b001: return rv32IsaPkg::aluSll;
			3'b010: return rv32IsaPkg::aluSlt;
			3'b011: return rv32IsaPkg::aluSltu;
			3'b100: return rv32IsaPkg::aluXor;
			3'b101: return alt ? rv32IsaPkg::aluSra : rv32IsaPkg::aluSrl;
			3'b110: return rv32IsaPkg::aluOr;
			default: return rv32IsaPkg::aluAnd;
		endcase
	endfunction

	assign opcode = rv32IsaPkg::opcodeT'(instruction[6:0]);
	assign funct3 = instruction[14:12];
	assign funct7 = instruction[31:25];
	assign rs1Index = instruction[19:15];
	assign rs2Index = instruction[24:20];
	assign rdIndex = instruction[11:7];
	assign iImmediate = {{(`XLEN-12){instruction[31]}}, instruction[31:20]};
	assign uImmediate = {instruction[31:12], 12'b0};

	always_comb begin
		aluOp = rv32IsaPkg::aluAdd;
		immediate = iImmediate;
		useImmediate = 1'b0;
		isLui = 1'b0;
		invalid = 1'b0;
		case (opcode)
			rv32IsaPkg::opcodeOp: begin
				aluOp = aluOpFor(funct3, funct7[5]);
				// Alternate encoding only exists for sub and sra
				invalid = !(funct7 == 7'b0000000 ||
					(funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101)));
			end
			rv32IsaPkg::opcodeOpImm: begin
				useImmediate = 1'b1;
				aluOp = aluOpFor(funct3, funct7[5] && funct3 == 3'b101);
				if (funct3 == 3'b001) begin
					invalid = funct7 != 7'b0000000;
				end else if (funct3 == 3'b101) begin
					invalid = funct7 != 7'b0000000 && funct7 != 7'b0100000;
				end
			end
			rv32IsaPkg::opcodeLui: begin
				aluOp = rv32IsaPkg::aluPassB;
				immediate = uImmediate;
				isLui = 1'b1;
			end
			default: invalid = 1'b1;
		endcase
	end

endmodule

// ==== src/registerFile.sv ====
`timescale 1ns/1ps
`include "rv32Core_defs.svh"

module registerFile (
	input logic clk,
	input logic rst,
	input logic [`REG_INDEX_BITS-1:0] rs1Index,
	input logic [`REG_INDEX_BITS-1:0] rs2Index,
	output logic [`XLEN-1:0] rs1Data,
	output logic [`XLEN-1:0] rs2Data,
	input logic writeEnable,
	input logic [`REG_INDEX_BITS-1:0] writeIndex,
	input logic [`XLEN-1:0] writeData,
	input logic mgmtEnable,
	input logic mgmtWrite,
	input logic [`REG_INDEX_BITS-1:0] mgmtIndex,
	input logic [`XLEN-1:0] mgmtWriteData,
	output logic [`XLEN-1:0] mgmtReadData
);

	// x0 has no storage
	logic [`XLEN-1:0] regs [1:`REG_COUNT-1];

	function automatic logic [`XLEN-1:0] readPort(input logic [`REG_INDEX_BITS-1:0] index);
		if (index == '0) return '0;
		// Writeback result in the same cycle
		if (writeEnable && writeIndex == index) return writeData;
		return regs[index];
	endfunction

	always_ff @(posedge clk) begin
		if (writeEnable && writeIndex != '0) begin
			regs[writeIndex] <= writeData;
		end else if (mgmtEnable && mgmtWrite && mgmtIndex != '0) begin
			regs[mgmtIndex] <= mgmtWriteData;
		end
	end

	assign rs1Data = readPort(rs1Index);
	assign rs2Data = readPort(rs2Index);
	assign mgmtReadData = (mgmtIndex == '0) ? '0 : regs[mgmtIndex];

	assert property (@(posedge clk) disable iff (rst)
		!(writeEnable && mgmtEnable && mgmtWrite));

endmodule

// ==== src/aluExecute.sv ====
`timescale 1ns/1ps
`include "rv32Core_defs.svh"

module aluExecute (
	input logic inValid,
	output logic inReady,
	input logic [`XLEN-1:0] pc,
	input rv32IsaPkg::aluOpT aluOp,
	input logic [`XLEN-1:0] rs1Data,
	input logic [`XLEN-1:0] rs2Data,
	input logic [`XLEN-1:0] immediate,
	input logic useImmediate,
	input logic isLui,
	input logic invalid,
	input logic [`REG_INDEX_BITS-1:0] rdIndex,
	output logic outValid,
	input logic outReady,
	output rv32IsaPkg::writebackPacketT outPacket,
	output logic retire,
	output logic faultDetected
);

	logic [`XLEN-1:0] operandA;
	logic [`XLEN-1:0] operandB;
	logic [4:0] shiftAmount;
	logic [`XLEN-1:0] result;
	logic bad;

	assign operandA = rs1Data;
	assign operandB = (useImmediate || isLui) ? immediate : rs2Data;
	assign shiftAmount = operandB[4:0];

	always_comb begin
		case (aluOp)
			rv32IsaPkg::aluAdd: result = operandA + operandB;
			rv32IsaPkg::aluSub: result = operandA - operandB;
			rv32IsaPkg::aluSll: result = operandA << shiftAmount;
			rv32IsaPkg::aluSlt: result = `XLEN'($signed(operandA) < $signed(operandB));
			rv32IsaPkg::aluSltu: result = `XLEN'(operandA < operandB);
			rv32IsaPkg::aluXor: result = operandA ^ operandB;
			rv32IsaPkg::aluSrl: result = operandA >> shiftAmount;
			rv32IsaPkg::aluSra: result = $unsigned($signed(operandA) >>> shiftAmount);
			rv32IsaPkg::aluOr: result = operandA | operandB;
			rv32IsaPkg::aluAnd: result = operandA & operandB;
			rv32IsaPkg::aluPassB: result = operandB;
			default: result = '0;
		endcase
	end

	// A misaligned program counter faults like a bad opcode
	assign bad = invalid || pc[1:0] != 2'b00;

	// Item is consumed whether it retires or faults
	assign inReady = outReady;
	assign outValid = inValid && !bad;
	assign retire = inValid && !bad && outReady;
	assign faultDetected = inValid && bad && outReady;

	assign outPacket.rdIndex = rdIndex;
	assign outPacket.writeEnable = rdIndex != '0;
	assign outPacket.result = result;

endmodule

// ==== src/managementControl.sv ====
`timescale 1ns/1ps
`include "rv32Core_defs.svh"

module managementControl (
	input logic clk,
	input logic rst,
	input logic mgmtRun,
	input logic mgmtWriteEnable,
	input logic [`MGMT_ADDR_BITS-1:0] mgmtAddress,
	input logic [`XLEN-1:0] mgmtWriteData,
	output logic pcWriteEnable,
	output logic regEnable,
	output logic regWrite,
	output logic [`REG_INDEX_BITS-1:0] regIndex,
	input logic faultDetected,
	output logic fault,
	input logic pipelineEmpty,
	output logic idle,
	input logic [`XLEN-1:0] programCounter,
	input logic [`XLEN-1:0] regReadData,
	output logic [`XLEN-1:0] mgmtReadData
);

	rv32MgmtPkg::mgmtRegionT region;
	rv32MgmtPkg::sysSelectT sysSelect;
	logic access;
	logic inSystem;
	logic selectPc;
	logic selectClearError;
	logic selectRegister;
	logic clearError;

	assign region = rv32MgmtPkg::mgmtRegionT'(mgmtAddress[`MGMT_REGION_HI:`MGMT_REGION_LO]);
	assign sysSelect = rv32MgmtPkg::sysSelectT'(mgmtAddress[`MGMT_SYS_SEL_HI:`MGMT_SYS_SEL_LO]);

	// Only whole words at their exact addresses
	assign inSystem = region == rv32MgmtPkg::regionSystem &&
		mgmtAddress[`MGMT_SYS_ZERO_HI:`MGMT_SYS_ZERO_LO] == '0 && mgmtAddress[3:0] == 4'h0;
	assign selectPc = inSystem && sysSelect == rv32MgmtPkg::sysProgramCounter;
	assign selectClearError = inSystem && sysSelect == rv32MgmtPkg::sysClearError;
	assign selectRegister = region == rv32MgmtPkg::regionRegisters &&
		mgmtAddress[`MGMT_REG_ZERO_HI:`MGMT_REG_ZERO_LO] == '0 && mgmtAddress[1:0] == 2'b00;

	assign access = !mgmtRun;
	assign pcWriteEnable = access && mgmtWriteEnable && selectPc;
	assign clearError = access && mgmtWriteEnable && selectClearError;
	assign regEnable = access && selectRegister;
	assign regWrite = mgmtWriteEnable;
	assign regIndex = mgmtAddress[`MGMT_REG_INDEX_HI:`MGMT_REG_INDEX_LO];

	always_ff @(posedge clk) begin
		if (rst) begin
			fault <= 1'b0;
			idle <= 1'b1;
		end else begin
			// Sticky until cleared over management
			if (faultDetected) fault <= 1'b1;
			else if (clearError) fault <= 1'b0;
			idle <= !mgmtRun && pipelineEmpty;
		end
	end

	always_comb begin
		if (access && selectPc) begin
			mgmtReadData = programCounter;
		end else if (access && selectRegister) begin
			mgmtReadData = regReadData;
		end else begin
			mgmtReadData = '1;
		end
	end

	// Writes to the program counter land only on a drained core
	assert property (@(posedge clk) disable iff (rst)
		pcWriteEnable |-> pipelineEmpty);

endmodule

// ==== src/rv32Core.sv ====
`timescale 1ns/1ps
`include "rv32Core_defs.svh"

module rv32Core (
	input logic clk,
	input logic rst,
	output logic instrReqValid,
	input logic instrReqReady,
	output logic [`XLEN-1:0] instrAddr,
	input logic instrRespValid,
	input logic [`XLEN-1:0] instrRespData,
	input logic mgmtRun,
	input logic mgmtWriteEnable,
	input logic [`MGMT_ADDR_BITS-1:0] mgmtAddress,
	input logic [`XLEN-1:0] mgmtWriteData,
	output logic [`XLEN-1:0] mgmtReadData,
	output logic idle,
	output logic fault
);

	logic fetchValid;
	logic fetchReady;
	rv32IsaPkg::fetchPacketT fetchPacket;
	logic stageValid;
	logic stageReady;
	rv32IsaPkg::fetchPacketT stageData;

	rv32IsaPkg::aluOpT aluOp;
	logic [`REG_INDEX_BITS-1:0] rs1Index;
	logic [`REG_INDEX_BITS-1:0] rs2Index;
	logic [`REG_INDEX_BITS-1:0] rdIndex;
	logic [`XLEN-1:0] immediate;
	logic useImmediate;
	logic isLui;
	logic invalid;
	logic [`XLEN-1:0] rs1Data;
	logic [`XLEN-1:0] rs2Data;

	logic aluValid;
	logic aluReady;
	rv32IsaPkg::writebackPacketT aluPacket;
	logic wbValid;
	logic wbInReady;
	rv32IsaPkg::writebackPacketT wbPacket;
	logic wbWrite;
	logic retire;
	logic faultDetected;

	logic [`XLEN-1:0] programCounter;
	logic [1:0] outstanding;
	logic pipelineEmpty;
	logic pcWriteEnable;
	logic regEnable;
	logic regWrite;
	logic [`REG_INDEX_BITS-1:0] regIndex;
	logic [`XLEN-1:0] regReadData;

	assign wbWrite = wbValid && wbPacket.writeEnable;
	assign pipelineEmpty = outstanding == 2'd0 && !instrReqValid && !wbValid;

	instructionFetch fetch0 (
		.clk(clk), .rst(rst), .run(mgmtRun), .halt(fault),
		.pcWriteEnable(pcWriteEnable), .pcWriteData(mgmtWriteData),
		.instrReqValid(instrReqValid), .instrReqReady(instrReqReady), .instrAddr(instrAddr),
		.instrRespValid(instrRespValid), .instrRespData(instrRespData),
		.fetchValid(fetchValid), .fetchReady(fetchReady), .fetchPacket(fetchPacket),
		.retire(retire), .discard(faultDetected),
		.programCounter(programCounter), .outstanding(outstanding));

	pipeStage #(.payloadT(rv32IsaPkg::fetchPacketT)) fetchStage0 (
		.clk(clk), .rst(rst),
		.inValid(fetchValid), .inReady(fetchReady), .inData(fetchPacket),
		.outValid(stageValid), .outReady(stageReady), .outData(stageData));

	instructionDecode decode0 (
		.instruction(stageData.instruction), .aluOp(aluOp),
		.rs1Index(rs1Index), .rs2Index(rs2Index), .rdIndex(rdIndex),
		.immediate(immediate), .useImmediate(useImmediate), .isLui(isLui), .invalid(invalid));

	registerFile regFile0 (
		.clk(clk), .rst(rst),
		.rs1Index(rs1Index), .rs2Index(rs2Index), .rs1Data(rs1Data), .rs2Data(rs2Data),
		.writeEnable(wbWrite), .writeIndex(wbPacket.rdIndex), .writeData(wbPacket.result),
		.mgmtEnable(regEnable), .mgmtWrite(regWrite), .mgmtIndex(regIndex),
		.mgmtWriteData(mgmtWriteData), .mgmtReadData(regReadData));

	aluExecute alu0 (
		.inValid(stageValid), .inReady(stageReady), .pc(stageData.pc), .aluOp(aluOp),
		.rs1Data(rs1Data), .rs2Data(rs2Data), .immediate(immediate),
		.useImmediate(useImmediate), .isLui(isLui), .invalid(invalid), .rdIndex(rdIndex),
		.outValid(aluValid), .outReady(aluReady), .outPacket(aluPacket),
		.retire(retire), .faultDetected(faultDetected));

	// Writeback always drains
	pipeStage #(.payloadT(rv32IsaPkg::writebackPacketT)) wbStage0 (
		.clk(clk), .rst(rst),
		.inValid(aluValid), .inReady(wbInReady), .inData(aluPacket),
		.outValid(wbValid), .outReady(1'b1), .outData(wbPacket));

	assign aluReady = wbInReady;

	managementControl mgmt0 (
		.clk(clk), .rst(rst),
		.mgmtRun(mgmtRun), .mgmtWriteEnable(mgmtWriteEnable),
		.mgmtAddress(mgmtAddress), .mgmtWriteData(mgmtWriteData),
		.pcWriteEnable(pcWriteEnable),
		.regEnable(regEnable), .regWrite(regWrite), .regIndex(regIndex),
		.faultDetected(faultDetected), .fault(fault),
		.pipelineEmpty(pipelineEmpty), .idle(idle),
		.programCounter(programCounter), .regReadData(regReadData),
		.mgmtReadData(mgmtReadData));

endmodule

// ==== testbench/rv32CoreTb.sv ====
`timescale 1ns/1ps
`include "rv32Core_defs.svh"

module rv32CoreTb;

	localparam int clkPeriod = 8;
	localparam int driveDelay = 1;
	localparam int testCount = 5;
	localparam int cyclesPerTest = 2000;
	localparam int waitLimit = 1000;

	logic clk;
	logic rst;
	logic instrReqValid;
	logic instrReqReady;
	logic [`XLEN-1:0] instrAddr;
	logic instrRespValid;
	logic [`XLEN-1:0] instrRespData;
	logic mgmtRun;
	logic mgmtWriteEnable;
	logic [`MGMT_ADDR_BITS-1:0] mgmtAddress;
	logic [`XLEN-1:0] mgmtWriteData;
	logic [`XLEN-1:0] mgmtReadData;
	logic idle;
	logic fault;

	// Memory model state
	logic [`XLEN-1:0] progMem [0:63];
	logic [`XLEN-1:0] pendAddr [$];
	int pendDue [$];
	int cycleCount;
	int readyPct;
	int maxDelay;
	logic lastTake;
	logic lastOffer;
	logic [`XLEN-1:0] takeAddr;

	logic [`XLEN-1:0] refRegs [0:`REG_COUNT-1];
	logic [`XLEN-1:0] programWords [$];
	int seedValue;

	rv32Core dut0 (
		.clk(clk), .rst(rst),
		.instrReqValid(instrReqValid), .instrReqReady(instrReqReady), .instrAddr(instrAddr),
		.instrRespValid(instrRespValid), .instrRespData(instrRespData),
		.mgmtRun(mgmtRun), .mgmtWriteEnable(mgmtWriteEnable), .mgmtAddress(mgmtAddress),
		.mgmtWriteData(mgmtWriteData), .mgmtReadData(mgmtReadData),
		.idle(idle), .fault(fault));

	initial begin
		clk = 1'b0;
		forever #(clkPeriod / 2) clk = ~clk;
	end

	initial begin
		#(testCount * cyclesPerTest * clkPeriod);
		$display("Timeout: the run did not complete within the cycle budget");
		abortRun();
	end

	// Unused words hold an invalid opcode tagged with their address
	function automatic logic [`XLEN-1:0] fillWord(input logic [`XLEN-1:0] addr);
		return {addr[31:7] ^ {18'b0, addr[6:0]}, 7'b1111111};
	endfunction

	function automatic logic [`XLEN-1:0] readWord(input logic [`XLEN-1:0] addr);
		if (addr < 32'd256) return progMem[addr[7:2]];
		return fillWord(addr);
	endfunction

	// In-order responses, each after its own random delay
	initial begin
		forever begin
			@(posedge clk);
			#driveDelay;
			cycleCount++;
			if (rst) begin
				pendAddr.delete();
				pendDue.delete();
				instrRespValid = 1'b0;
			end else begin
				// A request that was not taken must hold still
				if (lastOffer) begin
					checkFlag("instrReqValid", 1'b1, instrReqValid);
					checkWord("instrAddr", takeAddr, instrAddr);
				end
				if (lastTake) begin
					pendAddr.push_back(takeAddr);
					pendDue.push_back(cycleCount + int'($urandom % (maxDelay + 1)));
				end
				if (pendAddr.size() > 0 && pendDue[0] <= cycleCount) begin
					instrRespValid = 1'b1;
					instrRespData = readWord(pendAddr.pop_front());
					void'(pendDue.pop_front());
				end else begin
					instrRespValid = 1'b0;
				end
			end
			instrReqReady = int'($urandom % 100) < readyPct;
			lastTake = instrReqValid === 1'b1 && instrReqReady;
			lastOffer = instrReqValid === 1'b1 && !instrReqReady;
			takeAddr = instrAddr;
		end
	end

	function automatic logic [`XLEN-1:0] encR(input logic [6:0] f7, input logic [4:0] rs2,
			input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, 7'(rv32IsaPkg::opcodeOp)};
	endfunction

	function automatic logic [`XLEN-1:0] encI(input logic [11:0] imm, input logic [4:0] rs1,
			input logic [2:0] f3, input logic [4:0] rd);
		return {imm, rs1, f3, rd, 7'(rv32IsaPkg::opcodeOpImm)};
	endfunction

	function automatic logic [`XLEN-1:0] encU(input logic [19:0] imm, input logic [4:0] rd);
		return {imm, rd, 7'(rv32IsaPkg::opcodeLui)};
	endfunction

	function automatic logic [`MGMT_ADDR_BITS-1:0] regAddress(input logic [4:0] index);
		return {rv32MgmtPkg::regionRegisters, 7'b0, index, 2'b00};
	endfunction

	function automatic logic [`MGMT_ADDR_BITS-1:0] sysAddress(input rv32MgmtPkg::sysSelectT sel);
		return {rv32MgmtPkg::regionSystem, 6'b0, sel, 4'h0};
	endfunction

	// Reference model straight from the RV32I encodings
	task automatic refExecute(input logic [`XLEN-1:0] instr);
		logic [6:0] opcode;
		logic [2:0] f3;
		logic [`XLEN-1:0] a;
		logic [`XLEN-1:0] b;
		logic [`XLEN-1:0] r;
		logic [4:0] sh;
		opcode = instr[6:0];
		f3 = instr[14:12];
		a = refRegs[instr[19:15]];
		if (opcode == 7'(rv32IsaPkg::opcodeLui)) begin
			r = {instr[31:12], 12'b0};
		end else begin
			if (opcode == 7'(rv32IsaPkg::opcodeOp)) b = refRegs[instr[24:20]];
			else b = {{20{instr[31]}}, instr[31:20]};
			sh = b[4:0];
			case (f3)
				3'd0: r = (opcode == 7'(rv32IsaPkg::opcodeOp) && instr[30]) ? a - b : a + b;
				3'd1: r = a << sh;
				3'd2: r = {31'b0, $signed(a) < $signed(b)};
				3'd3: r = {31'b0, a < b};
				3'd4: r = a ^ b;
				3'd5: r = instr[30] ? $unsigned($signed(a) >>> sh) : a >> sh;
				3'd6: r = a | b;
				default: r = a & b;
			endcase
		end
		if (instr[11:7] != 5'd0) refRegs[instr[11:7]] = r;
	endtask

	task automatic abortRun();
		$display("test failed");
		$fatal(1);
	endtask

	task automatic checkWord(input string name, input logic [`XLEN-1:0] expected,
			input logic [`XLEN-1:0] actual);
		if (actual !== expected) begin
			$display("ERR %0t %s expected %h actual %h", $time, name, expected, actual);
			abortRun();
		end
	endtask

	task automatic checkFlag(input string name, input logic expected, input logic actual);
		if (actual !== expected) begin
			$display("ERR %0t %s expected %b actual %b", $time, name, expected, actual);
			abortRun();
		end
	endtask

	task automatic nextCycle();
		@(posedge clk);
		#driveDelay;
	endtask

	task automatic writeMgmt(input logic [`MGMT_ADDR_BITS-1:0] addr,
			input logic [`XLEN-1:0] data);
		mgmtAddress = addr;
		mgmtWriteData = data;
		mgmtWriteEnable = 1'b1;
		nextCycle();
		mgmtWriteEnable = 1'b0;
	endtask

	task automatic readMgmt(input logic [`MGMT_ADDR_BITS-1:0] addr,
			output logic [`XLEN-1:0] data);
		mgmtAddress = addr;
		mgmtWriteEnable = 1'b0;
		@(negedge clk);
		data = mgmtReadData;
		nextCycle();
	endtask

	task automatic checkAllRegisters();
		logic [`XLEN-1:0] value;
		int i;
		for (i = 0; i < `REG_COUNT; i++) begin
			readMgmt(regAddress(5'(i)), value);
			checkWord($sformatf("x%0d", i), refRegs[i], value);
		end
	endtask

	task automatic checkUnmapped(input logic [`MGMT_ADDR_BITS-1:0] addr);
		logic [`XLEN-1:0] value;
		readMgmt(addr, value);
		checkWord($sformatf("mgmtReadData@%h", addr), '1, value);
	endtask

	// Runs programWords from start; executed is the count before any fault
	task automatic runProgram(input logic [`XLEN-1:0] start, input int executed,
			input logic expectFault);
		logic [`XLEN-1:0] lastAddr;
		logic [`XLEN-1:0] value;
		int i;
		int waited;
		for (i = 0; i < 64; i++) progMem[i] = fillWord(32'(i * 4));
		for (i = 0; i < programWords.size(); i++) progMem[start[7:2] + i] = programWords[i];
		lastAddr = start + 32'(4 * (programWords.size() - 1));
		writeMgmt(sysAddress(rv32MgmtPkg::sysProgramCounter), start);
		mgmtRun = 1'b1;
		nextCycle();
		checkFlag("idle", 1'b0, idle);
		waited = 0;
		// Stop issuing once the last word is being requested
		while (expectFault ? fault !== 1'b1 :
				!(instrReqValid === 1'b1 && instrAddr == lastAddr)) begin
			nextCycle();
			waited++;
			if (waited > waitLimit) begin
				$display("Program at %h never reached its end condition", start);
				abortRun();
			end
		end
		mgmtRun = 1'b0;
		waited = 0;
		nextCycle();
		while (idle !== 1'b1) begin
			nextCycle();
			waited++;
			if (waited > waitLimit) begin
				$display("Core never went idle after the run was stopped");
				abortRun();
			end
		end
		for (i = 0; i < executed; i++) refExecute(programWords[i]);
		checkFlag("fault", expectFault, fault);
		checkAllRegisters();
		readMgmt(sysAddress(rv32MgmtPkg::sysProgramCounter), value);
		checkWord("programCounter", start + 32'(4 * executed), value);
	endtask

	task automatic testRegisterAccess();
		logic [`XLEN-1:0] value;
		int i;
		refRegs[0] = '0;
		for (i = 1; i < `REG_COUNT; i++) begin
			value = $urandom;
			refRegs[i] = value;
			writeMgmt(regAddress(5'(i)), value);
		end
		writeMgmt(regAddress(5'd0), 32'hDEAD_BEEF);
		checkAllRegisters();
		checkUnmapped(16'h0004);
		checkUnmapped(16'h0010);
		checkUnmapped(16'h0024);
		checkUnmapped(16'h4001);
		checkUnmapped(16'h4080);
		checkUnmapped(16'h8000);
		checkUnmapped(16'hC000);
	endtask

	task automatic testImmediateProgram();
		programWords.delete();
		programWords.push_back(encI(12'h123, 5'd0, 3'd0, 5'd1));
		programWords.push_back(encI(12'hFFB, 5'd1, 3'd0, 5'd2));
		programWords.push_back(encI(12'hFFF, 5'd2, 3'd2, 5'd3));
		programWords.push_back(encI(12'hFFF, 5'd2, 3'd3, 5'd4));
		programWords.push_back(encI(12'h5A5, 5'd2, 3'd4, 5'd5));
		programWords.push_back(encI(12'h0F0, 5'd5, 3'd6, 5'd6));
		programWords.push_back(encI(12'h3C3, 5'd6, 3'd7, 5'd7));
		programWords.push_back(encI({7'b0, 5'd7}, 5'd7, 3'd1, 5'd8));
		programWords.push_back(encU(20'h80000, 5'd9));
		programWords.push_back(encI({7'b0100000, 5'd12}, 5'd9, 3'd5, 5'd10));
		programWords.push_back(encI({7'b0, 5'd3}, 5'd9, 3'd5, 5'd11));
		programWords.push_back(encU(20'hABCDE, 5'd12));
		programWords.push_back(encI(12'h7FF, 5'd12, 3'd0, 5'd12));
		programWords.push_back(encU(20'h12345, 5'd0));
		programWords.push_back(encI(12'hFFF, 5'd0, 3'd0, 5'd13));
		programWords.push_back(encI(12'h000, 5'd13, 3'd2, 5'd14));
		runProgram(32'h40, programWords.size(), 1'b0);
	endtask

	// Every instruction reads the destination just written
	task automatic buildChain();
		programWords.delete();
		programWords.push_back(encR(7'h00, 5'd2, 5'd1, 3'd0, 5'd5));
		programWords.push_back(encR(7'h20, 5'd3, 5'd5, 3'd0, 5'd6));
		programWords.push_back(encR(7'h00, 5'd4, 5'd6, 3'd1, 5'd7));
		programWords.push_back(encR(7'h00, 5'd6, 5'd7, 3'd2, 5'd8));
		programWords.push_back(encR(7'h00, 5'd7, 5'd8, 3'd3, 5'd9));
		programWords.push_back(encR(7'h00, 5'd1, 5'd9, 3'd4, 5'd10));
		programWords.push_back(encR(7'h00, 5'd2, 5'd10, 3'd5, 5'd11));
		programWords.push_back(encR(7'h20, 5'd3, 5'd11, 3'd5, 5'd12));
		programWords.push_back(encR(7'h00, 5'd5, 5'd12, 3'd6, 5'd13));
		programWords.push_back(encR(7'h00, 5'd6, 5'd13, 3'd7, 5'd14));
		programWords.push_back(encR(7'h00, 5'd14, 5'd14, 3'd0, 5'd15));
		programWords.push_back(encR(7'h20, 5'd0, 5'd15, 3'd0, 5'd16));
	endtask

	task automatic testDependentChain();
		buildChain();
		runProgram(32'h10, programWords.size(), 1'b0);
	endtask

	// Same chain through a slow memory that rarely takes requests
	task automatic testBackPressure();
		readyPct = 20;
		maxDelay = 12;
		testDependentChain();
		readyPct = 70;
		maxDelay = 3;
	endtask

	task automatic testFaultProgram();
		programWords.delete();
		programWords.push_back(encI(12'd100, 5'd0, 3'd0, 5'd1));
		programWords.push_back(encI(12'd23, 5'd1, 3'd0, 5'd2));
		programWords.push_back(encU(20'h0F00D, 5'd3));
		// Custom-0 opcode
		programWords.push_back(32'h00A5_800B);
		programWords.push_back(encI(12'd1, 5'd0, 3'd0, 5'd4));
		programWords.push_back(encI(12'd2, 5'd0, 3'd0, 5'd5));
		runProgram(32'h80, 3, 1'b1);
		writeMgmt(sysAddress(rv32MgmtPkg::sysClearError), '0);
		checkFlag("fault", 1'b0, fault);
	endtask

	initial begin
		seedValue = $urandom(73112);
		cycleCount = 0;
		readyPct = 70;
		maxDelay = 3;
		lastTake = 1'b0;
		lastOffer = 1'b0;
		takeAddr = '0;
		rst = 1'b1;
		instrReqReady = 1'b0;
		instrRespValid = 1'b0;
		instrRespData = '0;
		mgmtRun = 1'b0;
		mgmtWriteEnable = 1'b0;
		mgmtAddress = '0;
		mgmtWriteData = '0;
		repeat (5) @(posedge clk);
		#driveDelay;
		rst = 1'b0;
		nextCycle();
		testRegisterAccess();
		testImmediateProgram();
		testDependentChain();
		testBackPressure();
		testFaultProgram();
		$display("test passed");
		$finish;
	end

endmodule

// ==== rv32Core.f ====
+incdir+src
src/rv32IsaPkg.sv
src/rv32MgmtPkg.sv
src/pipeStage.sv
src/instructionFetch.sv
src/instructionDecode.sv
src/registerFile.sv
src/aluExecute.sv
src/managementControl.sv
src/rv32Core.sv
testbench/rv32CoreTb.sv
